// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_peripheral_bus
FILELIST  = peripheral_bus.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# build and run, exit status carries pass or fail
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: peripheral_bus.f
+incdir+source
source/pbus_pkg.sv
source/pbus_regs_pkg.sv
source/pbus_decoder.sv
source/pbus_gpio.sv
source/pbus_timer.sv
source/pbus_response.sv
source/peripheral_bus.sv
verification/pbus_checker.sv
verification/tb_peripheral_bus.sv

// File: source/pbus_decoder.sv
// decode stage of the peripheral bus
// request capture, target decode, per-peripheral write strobes

`timescale 1ns/1ps

`include "pbus_defines.svh"

module pbus_decoder
    import pbus_pkg::*;
    import pbus_regs_pkg::*;
(
    input  logic                        clock_i,
    input  logic                        reset_i,
    // host request, taken every valid cycle
    input  logic                        req_valid_i,
    input  logic                        req_write_i,
    input  logic [`PBUS_ADDR_WIDTH-1:0] req_addr_i,
    input  logic [`PBUS_DATA_WIDTH-1:0] req_wdata_i,
    // stage 1
    output logic                        stage_valid_o,
    output pbus_op_e                    stage_op_o,
    output pbus_target_e                stage_target_o,
    output logic [1:0]                  stage_offset_o,
    output logic [`PBUS_DATA_WIDTH-1:0] stage_wdata_o,
    output logic                        gpio_wr_o,
    output logic                        timer_wr_o
);

    pbus_target_e req_target; // from the region nibble

    always_comb begin
        case (req_addr_i[REGION_MSB:REGION_LSB])
            REGION_GPIO:  req_target = TGT_GPIO;
            REGION_TIMER: req_target = TGT_TIMER;
            default:      req_target = TGT_NONE; // unmapped, answers with error
        endcase
    end

    ////////////////////////////////////////////////////////////
    // stage 1 registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            stage_valid_o <= 1'b0;
            gpio_wr_o     <= 1'b0;
            timer_wr_o    <= 1'b0;
        end else begin
            stage_valid_o <= req_valid_i;
            gpio_wr_o     <= req_valid_i && req_write_i && (req_target == TGT_GPIO);
            timer_wr_o    <= req_valid_i && req_write_i && (req_target == TGT_TIMER);
        end
    end

    // payload only moves with a request
    always_ff @(posedge clock_i) begin
        if (req_valid_i) begin
            stage_op_o     <= req_write_i ? OP_WRITE : OP_READ;
            stage_target_o <= req_target;
            stage_offset_o <= req_addr_i[OFFSET_MSB:OFFSET_LSB]; // word select
            stage_wdata_o  <= req_wdata_i;
        end
    end

endmodule : pbus_decoder

// File: source/pbus_defines.svh
// widths and sizes of the peripheral bus
// register data, byte address, gpio pin counts, interrupt vector

`ifndef PBUS_DEFINES_SVH
`define PBUS_DEFINES_SVH

////////////////////////////////////////////////////////////
// bus
////////////////////////////////////////////////////////////

`define PBUS_DATA_WIDTH      32 // one register word
`define PBUS_ADDR_WIDTH      12 // byte address, 16 regions of 256 bytes

////////////////////////////////////////////////////////////
// pins and interrupts
////////////////////////////////////////////////////////////

`define PBUS_GPIO_IN_WIDTH   8  // input pins
`define PBUS_GPIO_OUT_WIDTH  8  // output pins
`define PBUS_NUM_IRQ         2  // gpio and timer lines

`endif

// File: source/pbus_gpio.sv
// gpio peripheral
// output register, two-flop input synchronizer, change detect with pending/enable irq

`timescale 1ns/1ps

`include "pbus_defines.svh"

module pbus_gpio
    import pbus_regs_pkg::*;
(
    input  logic                            clock_i,
    input  logic                            reset_i,
    input  logic                            wr_i,      // one-cycle strobe from decode
    input  logic [1:0]                      offset_i,
    input  logic [`PBUS_DATA_WIDTH-1:0]     wdata_i,
    input  logic [`PBUS_GPIO_IN_WIDTH-1:0]  gpio_in_i,  // asynchronous pins
    output logic [`PBUS_DATA_WIDTH-1:0]     rdata_o,    // combinational by offset
    output logic [`PBUS_GPIO_OUT_WIDTH-1:0] gpio_out_o,
    output logic                            irq_o
);

    logic [`PBUS_GPIO_OUT_WIDTH-1:0] out_q;
    logic [`PBUS_GPIO_IN_WIDTH-1:0]  sync1_q, sync2_q; // synchronizer chain
    logic [`PBUS_GPIO_IN_WIDTH-1:0]  prev_q;           // last synchronized value
    logic [`PBUS_GPIO_IN_WIDTH-1:0]  enable_q, pending_q;
    logic [`PBUS_GPIO_IN_WIDTH-1:0]  change, pend_clr;

    assign change   = sync2_q ^ prev_q; // any edge
    assign pend_clr = (wr_i && (offset_i == GPIO_PENDING)) ?
                      wdata_i[`PBUS_GPIO_IN_WIDTH-1:0] : '0;

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            out_q     <= '0;
            enable_q  <= '0;
            pending_q <= '0;
            sync1_q   <= '0;
            sync2_q   <= '0;
            prev_q    <= '0;
        end else begin
            sync1_q   <= gpio_in_i;
            sync2_q   <= sync1_q;
            prev_q    <= sync2_q;
            pending_q <= (pending_q & ~pend_clr) | change; // new change beats clear
            if (wr_i) begin
                case (offset_i)
                    GPIO_OUT:    out_q    <= wdata_i[`PBUS_GPIO_OUT_WIDTH-1:0];
                    GPIO_ENABLE: enable_q <= wdata_i[`PBUS_GPIO_IN_WIDTH-1:0];
                    default:     ; // IN read only, PENDING handled above
                endcase
            end
        end
    end

    always_comb begin
        rdata_o = '0; // upper bits read zero
        case (offset_i)
            GPIO_OUT:     rdata_o[`PBUS_GPIO_OUT_WIDTH-1:0] = out_q;
            GPIO_IN:      rdata_o[`PBUS_GPIO_IN_WIDTH-1:0]  = sync2_q;
            GPIO_PENDING: rdata_o[`PBUS_GPIO_IN_WIDTH-1:0]  = pending_q;
            GPIO_ENABLE:  rdata_o[`PBUS_GPIO_IN_WIDTH-1:0]  = enable_q;
        endcase
    end

    assign gpio_out_o = out_q;
    assign irq_o      = |(pending_q & enable_q); // any enabled pending bit

endmodule : pbus_gpio

// File: source/pbus_pkg.sv
// bus level types
// request opcode and addressed peripheral

package pbus_pkg;

    ////////////////////////////////////////////////////////////
    // request
    ////////////////////////////////////////////////////////////

    // taken from the host write bit
    typedef enum logic {
        OP_READ  = 1'b0, // returns register data
        OP_WRITE = 1'b1  // returns zero data
    } pbus_op_e;

    ////////////////////////////////////////////////////////////
    // decode result
    ////////////////////////////////////////////////////////////

    // TGT_NONE answers with the error flag
    typedef enum logic [1:0] {
        TGT_GPIO  = 2'd0, // region 0
        TGT_TIMER = 2'd1, // region 1
        TGT_NONE  = 2'd2  // any other region
    } pbus_target_e;

endpackage

// File: source/pbus_regs_pkg.sv
// register map of the peripheral bus
// address fields, region codes, register offsets, interrupt indices

`include "pbus_defines.svh"

package pbus_regs_pkg;

    localparam int REGION_MSB = `PBUS_ADDR_WIDTH - 1; // region is the top nibble
    localparam int REGION_LSB = 8;
    localparam int OFFSET_MSB = 3;                    // word offset in a region
    localparam int OFFSET_LSB = 2;

    localparam logic [3:0] REGION_GPIO  = 4'h0;
    localparam logic [3:0] REGION_TIMER = 4'h1;

    typedef enum logic [1:0] {
        GPIO_OUT     = 2'd0, // read/write, drives the pins
        GPIO_IN      = 2'd1, // read only, synchronized pins
        GPIO_PENDING = 2'd2, // change flags, write one to clear
        GPIO_ENABLE  = 2'd3  // interrupt mask
    } gpio_reg_e;

    typedef enum logic [1:0] {
        TIM_CONTROL = 2'd0, // enable and auto-reload
        TIM_LOAD    = 2'd1, // start and reload value
        TIM_COUNT   = 2'd2, // read only
        TIM_STATUS  = 2'd3  // pending flag, write one to clear
    } timer_reg_e;

    localparam int TIM_CTRL_EN = 0; // control bit positions
    localparam int TIM_CTRL_AR = 1;

    localparam int IRQ_GPIO  = 0;   // interrupt vector lines
    localparam int IRQ_TIMER = 1;

endpackage

// File: source/pbus_response.sv
// response stage of the peripheral bus
// read data select by target, registered valid pulse, data and error

`timescale 1ns/1ps

`include "pbus_defines.svh"

module pbus_response
    import pbus_pkg::*;
(
    input  logic                        clock_i,
    input  logic                        reset_i,
    input  logic                        stage_valid_i,
    input  pbus_op_e                    stage_op_i,
    input  pbus_target_e                stage_target_i,
    input  logic [`PBUS_DATA_WIDTH-1:0] gpio_rdata_i,
    input  logic [`PBUS_DATA_WIDTH-1:0] timer_rdata_i,
    output logic                        resp_valid_o,  // one-cycle pulse
    output logic [`PBUS_DATA_WIDTH-1:0] resp_rdata_o,
    output logic                        resp_error_o   // unmapped region
);

    logic [`PBUS_DATA_WIDTH-1:0] sel_rdata;

    always_comb begin
        sel_rdata = '0; // writes return zero
        if (stage_op_i == OP_READ) begin
            case (stage_target_i)
                TGT_GPIO:  sel_rdata = gpio_rdata_i;
                TGT_TIMER: sel_rdata = timer_rdata_i;
                default:   sel_rdata = '0; // TGT_NONE
            endcase
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            resp_valid_o <= 1'b0;
            resp_error_o <= 1'b0;
        end else begin
            resp_valid_o <= stage_valid_i;
            resp_error_o <= stage_valid_i && (stage_target_i == TGT_NONE);
        end
    end

    always_ff @(posedge clock_i) begin
        resp_rdata_o <= sel_rdata; // meaningful only with valid
    end

endmodule : pbus_response

// File: source/pbus_timer.sv
// timer peripheral
// 32-bit down-counter, load and auto-reload, pending interrupt

`timescale 1ns/1ps

`include "pbus_defines.svh"

module pbus_timer
    import pbus_regs_pkg::*;
(
    input  logic                        clock_i,
    input  logic                        reset_i,
    input  logic                        wr_i,     // one-cycle strobe from decode
    input  logic [1:0]                  offset_i,
    input  logic [`PBUS_DATA_WIDTH-1:0] wdata_i,
    output logic [`PBUS_DATA_WIDTH-1:0] rdata_o,  // combinational by offset
    output logic                        irq_o
);

    logic                        enable_q;
    logic                        reload_q;  // auto-reload
    logic                        pending_q;
    logic [`PBUS_DATA_WIDTH-1:0] load_q;
    logic [`PBUS_DATA_WIDTH-1:0] count_q;
    logic                        ctrl_wr, load_wr, status_clr;
    logic                        expire;    // zero reached while running

    assign ctrl_wr    = wr_i && (offset_i == TIM_CONTROL);
    assign load_wr    = wr_i && (offset_i == TIM_LOAD);
    assign status_clr = wr_i && (offset_i == TIM_STATUS) && wdata_i[0]; // w1c
    assign expire     = enable_q && (count_q == '0);

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            load_q <= '0;
        end else if (load_wr) begin
            load_q <= wdata_i; // no effect on a running count
        end
    end

    ////////////////////////////////////////////////////////////
    // counter and control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            enable_q <= 1'b0;
            reload_q <= 1'b0;
            count_q  <= '0;
        end else if (ctrl_wr) begin
            enable_q <= wdata_i[TIM_CTRL_EN];
            reload_q <= wdata_i[TIM_CTRL_AR];
            if (wdata_i[TIM_CTRL_EN]) begin
                count_q <= load_q; // start from LOAD
            end
        end else if (expire) begin
            if (reload_q) begin
                count_q <= load_q; // periodic
            end else begin
                enable_q <= 1'b0;  // one-shot stops
            end
        end else if (enable_q) begin
            count_q <= count_q - 1;
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            pending_q <= 1'b0;
        end else if (expire) begin
            pending_q <= 1'b1; // set wins over clear
        end else if (status_clr) begin
            pending_q <= 1'b0;
        end
    end

    always_comb begin
        rdata_o = '0;
        case (offset_i)
            TIM_CONTROL: begin
                rdata_o[TIM_CTRL_EN] = enable_q;
                rdata_o[TIM_CTRL_AR] = reload_q;
            end
            TIM_LOAD:    rdata_o    = load_q;
            TIM_COUNT:   rdata_o    = count_q;
            TIM_STATUS:  rdata_o[0] = pending_q;
        endcase
    end

    assign irq_o = pending_q;

endmodule : pbus_timer

// File: source/peripheral_bus.sv
// peripheral bus top level
// decode, gpio, timer and response instances, interrupt vector

`timescale 1ns/1ps

`include "pbus_defines.svh"

module peripheral_bus
    import pbus_pkg::*;
    import pbus_regs_pkg::*;
(
    input  logic                            clock_i,
    input  logic                            reset_i,
    // host side
    input  logic                            req_valid_i,
    input  logic                            req_write_i,
    input  logic [`PBUS_ADDR_WIDTH-1:0]     req_addr_i,
    input  logic [`PBUS_DATA_WIDTH-1:0]     req_wdata_i,
    output logic                            resp_valid_o,
    output logic [`PBUS_DATA_WIDTH-1:0]     resp_rdata_o,
    output logic                            resp_error_o,
    // pins
    input  logic [`PBUS_GPIO_IN_WIDTH-1:0]  gpio_in_i,
    output logic [`PBUS_GPIO_OUT_WIDTH-1:0] gpio_out_o,
    output logic [`PBUS_NUM_IRQ-1:0]        int_o
);

    ////////////////////////////////////////////////////////////
    // stage 1 wires
    ////////////////////////////////////////////////////////////

    logic                        stage_valid;
    pbus_op_e                    stage_op;
    pbus_target_e                stage_target;
    logic [1:0]                  stage_offset;  // shared by both peripherals
    logic [`PBUS_DATA_WIDTH-1:0] stage_wdata;
    logic                        gpio_wr, timer_wr;
    logic [`PBUS_DATA_WIDTH-1:0] gpio_rdata, timer_rdata;
    logic                        gpio_irq, timer_irq;

    assign int_o[IRQ_GPIO]  = gpio_irq;
    assign int_o[IRQ_TIMER] = timer_irq;

    pbus_decoder decoder_u (
        .clock_i        ( clock_i      ),
        .reset_i        ( reset_i      ),
        .req_valid_i    ( req_valid_i  ),
        .req_write_i    ( req_write_i  ),
        .req_addr_i     ( req_addr_i   ),
        .req_wdata_i    ( req_wdata_i  ),
        .stage_valid_o  ( stage_valid  ),
        .stage_op_o     ( stage_op     ),
        .stage_target_o ( stage_target ),
        .stage_offset_o ( stage_offset ),
        .stage_wdata_o  ( stage_wdata  ),
        .gpio_wr_o      ( gpio_wr      ),
        .timer_wr_o     ( timer_wr     )
    );

    pbus_gpio gpio_u (
        .clock_i    ( clock_i      ),
        .reset_i    ( reset_i      ),
        .wr_i       ( gpio_wr      ),
        .offset_i   ( stage_offset ),
        .wdata_i    ( stage_wdata  ),
        .gpio_in_i  ( gpio_in_i    ),
        .rdata_o    ( gpio_rdata   ),
        .gpio_out_o ( gpio_out_o   ),
        .irq_o      ( gpio_irq     )
    );

    pbus_timer timer_u (
        .clock_i  ( clock_i      ),
        .reset_i  ( reset_i      ),
        .wr_i     ( timer_wr     ),
        .offset_i ( stage_offset ),
        .wdata_i  ( stage_wdata  ),
        .rdata_o  ( timer_rdata  ),
        .irq_o    ( timer_irq    )
    );

    pbus_response response_u (
        .clock_i        ( clock_i      ),
        .reset_i        ( reset_i      ),
        .stage_valid_i  ( stage_valid  ),
        .stage_op_i     ( stage_op     ),
        .stage_target_i ( stage_target ),
        .gpio_rdata_i   ( gpio_rdata   ),
        .timer_rdata_i  ( timer_rdata  ),
        .resp_valid_o   ( resp_valid_o ),
        .resp_rdata_o   ( resp_rdata_o ),
        .resp_error_o   ( resp_error_o )
    );

endmodule : peripheral_bus

// File: verification/pbus_checker.sv
// protocol assertions for the peripheral bus top level
// response latency, error qualified by valid, quiet interrupts after reset

`timescale 1ns/1ps

`include "pbus_defines.svh"

module pbus_checker (
    input logic                     clock_i,
    input logic                     reset_i,
    input logic                     req_valid_i,
    input logic                     resp_valid_o,
    input logic                     resp_error_o,
    input logic [`PBUS_NUM_IRQ-1:0] int_o
);

    // fixed two-cycle latency
    latency_a: assert property (@(posedge clock_i) disable iff (reset_i)
        resp_valid_o == $past(req_valid_i, 2)) else $error("response latency broken");

    error_a: assert property (@(posedge clock_i) disable iff (reset_i)
        resp_error_o |-> resp_valid_o) else $error("error flag without valid");

    irq_reset_a: assert property (@(posedge clock_i)
        $fell(reset_i) |-> int_o == '0) else $error("interrupt set right after reset");

endmodule : pbus_checker

bind peripheral_bus pbus_checker checker_u (
    .clock_i      ( clock_i      ),
    .reset_i      ( reset_i      ),
    .req_valid_i  ( req_valid_i  ),
    .resp_valid_o ( resp_valid_o ),
    .resp_error_o ( resp_error_o ),
    .int_o        ( int_o        )
);

// File: verification/tb_peripheral_bus.sv
// testbench for the peripheral bus
// clock, reset, lfsr stimulus, cycle model of pipeline, gpio and timer, checks, timeout

`timescale 1ns/1ps

`include "pbus_defines.svh"

module tb_peripheral_bus
    import pbus_pkg::*;
    import pbus_regs_pkg::*;
;
    localparam int TEST_CYCLES = 16 + 64 + 48 + 100 + 40 + 80; // reset plus tests 1 to 5
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    logic                            clock_i = 1'b0;
    logic                            reset_i = 1'b1;
    logic                            req_valid_i = 1'b0;
    logic                            req_write_i = 1'b0;
    logic [`PBUS_ADDR_WIDTH-1:0]     req_addr_i = '0;
    logic [`PBUS_DATA_WIDTH-1:0]     req_wdata_i = '0;
    logic [`PBUS_GPIO_IN_WIDTH-1:0]  gpio_in_i = '0;
    logic                            resp_valid_o, resp_error_o;
    logic [`PBUS_DATA_WIDTH-1:0]     resp_rdata_o;
    logic [`PBUS_GPIO_OUT_WIDTH-1:0] gpio_out_o;
    logic [`PBUS_NUM_IRQ-1:0]        int_o;

    logic [15:0] lfsr_q = 16'd57281;              // fixed seed
    logic [`PBUS_GPIO_IN_WIDTH-1:0] pins = '0;    // pin value for the next cycle
    int          cycle_count = 0;

    // model state
    logic         m_s1_valid = 1'b0, m_s1_write = 1'b0;
    pbus_target_e m_s1_target = TGT_NONE;
    logic [1:0]   m_s1_offset = 2'd0;
    logic [31:0]  m_s1_wdata = '0;
    logic         m_resp_valid = 1'b0, m_resp_error = 1'b0;
    logic [31:0]  m_resp_rdata = '0;
    logic [7:0]   m_out = '0, m_enable = '0, m_pending = '0;
    logic [7:0]   m_sync1 = '0, m_sync2 = '0, m_prev = '0;
    logic         m_ten = 1'b0, m_tar = 1'b0, m_tpend = 1'b0;
    logic [31:0]  m_load = '0, m_count = '0;

    peripheral_bus dut0 (.*);

    always #20 clock_i = ~clock_i; // 40 ns period

    always @(posedge clock_i) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("run exceeded its cycle limit without finishing");
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]; // x16+x14+x13+x11
            lfsr_q = {lfsr_q[14:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    // region and offset, ignored bits random
    function automatic logic [11:0] make_addr(input logic [3:0] region, input logic [1:0] offset);
        logic [31:0] mid, low;
        mid = rand_bits(4);
        low = rand_bits(2);
        return {region, mid[3:0], offset, low[1:0]};
    endfunction

    function automatic pbus_target_e decode_region(input logic [3:0] region);
        if (region == 4'h0) return TGT_GPIO;
        if (region == 4'h1) return TGT_TIMER;
        return TGT_NONE;
    endfunction

    function automatic logic [31:0] read_model(input pbus_target_e tgt, input logic [1:0] off);
        if (tgt == TGT_GPIO) begin
            case (off)
                2'd0:    return {24'd0, m_out};
                2'd1:    return {24'd0, m_sync2};
                2'd2:    return {24'd0, m_pending};
                default: return {24'd0, m_enable};
            endcase
        end else if (tgt == TGT_TIMER) begin
            case (off)
                2'd0:    return {30'd0, m_tar, m_ten};
                2'd1:    return m_load;
                2'd2:    return m_count;
                default: return {31'd0, m_tpend};
            endcase
        end
        return '0;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "check failed");
    endtask

    task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // model, one clock edge
    ////////////////////////////////////////////////////////////

    task automatic model_edge(input logic v, input logic w, input logic [11:0] a,
                              input logic [31:0] wd);
        logic gwr, twr, expire;
        logic [7:0] clr;
        gwr    = m_s1_valid && m_s1_write && (m_s1_target == TGT_GPIO);
        twr    = m_s1_valid && m_s1_write && (m_s1_target == TGT_TIMER);
        expire = m_ten && (m_count == 32'd0);
        // response from stage 1
        m_resp_valid = m_s1_valid;
        m_resp_error = m_s1_valid && (m_s1_target == TGT_NONE);
        m_resp_rdata = m_s1_write ? 32'd0 : read_model(m_s1_target, m_s1_offset);
        // gpio
        clr       = (gwr && m_s1_offset == 2'd2) ? m_s1_wdata[7:0] : 8'd0;
        m_pending = (m_pending & ~clr) | (m_sync2 ^ m_prev); // change wins
        m_prev    = m_sync2;
        m_sync2   = m_sync1;
        m_sync1   = pins;
        if (gwr && m_s1_offset == 2'd0) m_out = m_s1_wdata[7:0];
        if (gwr && m_s1_offset == 2'd3) m_enable = m_s1_wdata[7:0];
        // timer, pending set beats clear
        if (expire) m_tpend = 1'b1;
        else if (twr && m_s1_offset == 2'd3 && m_s1_wdata[0]) m_tpend = 1'b0;
        if (twr && m_s1_offset == 2'd0) begin
            m_ten = m_s1_wdata[0];
            m_tar = m_s1_wdata[1];
            if (m_s1_wdata[0]) m_count = m_load;
        end else if (expire) begin
            if (m_tar) m_count = m_load;
            else m_ten = 1'b0;
        end else if (m_ten) begin
            m_count = m_count - 32'd1;
        end
        if (twr && m_s1_offset == 2'd1) m_load = m_s1_wdata;
        // stage 1 capture
        m_s1_valid = v;
        if (v) begin
            m_s1_write  = w;
            m_s1_target = decode_region(a[11:8]);
            m_s1_offset = a[3:2];
            m_s1_wdata  = wd;
        end
    endtask

    // one bus cycle, called at edge plus 2 ns
    task automatic cycle(input logic v, input logic w, input logic [11:0] a,
                         input logic [31:0] wd);
        req_valid_i = v;
        req_write_i = w;
        req_addr_i  = a;
        req_wdata_i = wd;
        gpio_in_i   = pins;
        @(posedge clock_i);
        model_edge(v, w, a, wd);
        #1;
        compare_value("resp_valid_o", {31'd0, m_resp_valid}, {31'd0, resp_valid_o});
        if (m_resp_valid) begin
            compare_value("resp_error_o", {31'd0, m_resp_error}, {31'd0, resp_error_o});
            compare_value("resp_rdata_o", m_resp_rdata, resp_rdata_o);
        end
        compare_value("gpio_out_o", {24'd0, m_out}, {24'd0, gpio_out_o});
        compare_value("int_o[IRQ_GPIO]", {31'd0, |(m_pending & m_enable)},
                      {31'd0, int_o[IRQ_GPIO]});
        compare_value("int_o[IRQ_TIMER]", {31'd0, m_tpend}, {31'd0, int_o[IRQ_TIMER]});
        #1;
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++) cycle(1'b0, 1'b0, 12'h000, 32'd0);
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r, wd, ld;
        int          waited, rises, last_rise, iter;
        logic        prev_irq, clear_next;
        repeat (16) @(posedge clock_i);
        #2 reset_i = 1'b0;

        // 1: back-to-back r/w on out, enable, load
        for (int i = 0; i < 64; i++) begin
            r  = rand_bits(2);
            wd = rand_bits(32);
            case (r[1:0])
                2'd1:    cycle(1'b1, wd[5], make_addr(4'h0, 2'd3), wd);
                2'd2:    cycle(1'b1, wd[5], make_addr(4'h1, 2'd1), wd);
                default: cycle(1'b1, wd[5], make_addr(4'h0, 2'd0), wd);
            endcase
        end

        // 2: unmapped regions, read-only writes
        for (int i = 0; i < 48; i++) begin
            r  = rand_bits(6);
            wd = rand_bits(32);
            if (r[5:4] == 2'd2) cycle(1'b1, r[0], make_addr(4'h0, 2'd1), wd);       // GPIO_IN
            else if (r[5:4] == 2'd3) cycle(1'b1, r[0], make_addr(4'h1, 2'd2), wd);  // TIM_COUNT
            else cycle(1'b1, r[0], make_addr((r[3:0] < 4'd2) ? r[3:0] + 4'd2 : r[3:0], wd[3:2]),
                       wd);
        end

        // 3: pin changes, pending, w1c
        wd = rand_bits(32);
        cycle(1'b1, 1'b1, make_addr(4'h0, 2'd3), wd);
        for (int i = 0; i < 12; i++) begin
            r    = rand_bits(8);
            pins = r[7:0];
            for (int j = 0; j < 6; j++) cycle(1'b1, 1'b0, make_addr(4'h0, 2'd2), 32'd0);
            cycle(1'b1, 1'b1, make_addr(4'h0, 2'd2), rand_bits(8));
        end
        idle(4);

        // 4: one-shot
        r  = rand_bits(3);
        ld = {29'd0, r[2:0]} + 32'd1;
        cycle(1'b1, 1'b1, make_addr(4'h1, 2'd1), ld);
        cycle(1'b1, 1'b1, make_addr(4'h1, 2'd0), 32'd1);
        idle(1);                                   // control write lands here
        waited = 0;
        while (int_o[IRQ_TIMER] !== 1'b1 && waited < 32) begin
            idle(1);
            waited++;
        end
        assert (waited == int'(ld) + 1)
            else report_failure("one-shot interrupt came at the wrong cycle");
        cycle(1'b1, 1'b0, make_addr(4'h1, 2'd0), 32'd0);
        idle(1);
        compare_value("resp_rdata_o[0]", 32'd0, {31'd0, resp_rdata_o[0]}); // enable cleared
        cycle(1'b1, 1'b1, make_addr(4'h1, 2'd3), 32'd1);
        idle(3);
        compare_value("int_o[IRQ_TIMER]", 32'd0, {31'd0, int_o[IRQ_TIMER]});

        // 5: auto-reload, spacing and running count
        r  = rand_bits(3);
        ld = {29'd0, r[2:0]} + 32'd4;
        cycle(1'b1, 1'b1, make_addr(4'h1, 2'd1), ld);
        cycle(1'b1, 1'b1, make_addr(4'h1, 2'd0), 32'd3);
        rises      = 0;
        last_rise  = 0;
        iter       = 0;
        prev_irq   = 1'b0;
        clear_next = 1'b0;
        while (rises < 4 && iter < 70) begin
            if (clear_next) cycle(1'b1, 1'b1, make_addr(4'h1, 2'd3), 32'd1);
            else cycle(1'b1, 1'b0, make_addr(4'h1, 2'd2), 32'd0);
            clear_next = 1'b0;
            if (int_o[IRQ_TIMER] && !prev_irq) begin
                if (rises > 0) begin
                    assert (iter - last_rise == int'(ld) + 1)
                        else report_failure("auto-reload interrupts are not evenly spaced");
                end
                last_rise  = iter;
                rises++;
                clear_next = 1'b1;
            end
            prev_irq = int_o[IRQ_TIMER];
            iter++;
        end
        assert (rises >= 4) else report_failure("auto-reload timer stopped interrupting");
        cycle(1'b1, 1'b1, make_addr(4'h1, 2'd0), 32'd0);
        idle(4);

        $display("TEST PASS");
        $finish;
    end

endmodule : tb_peripheral_bus
